//--- filelist.f
+incdir+logic
logic/core_pkg.sv
logic/core_queue.sv
logic/core_fetch.sv
logic/core_data_port.sv
logic/core_bus_arbiter.sv
logic/core_memsys.sv
verification/memsys_checker.sv
verification/memsys_tb.sv

//--- Bender.yml
package:
  name: core_memsys

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_pkg.sv
      - logic/core_queue.sv
      - logic/core_fetch.sv
      - logic/core_data_port.sv
      - logic/core_bus_arbiter.sv
      - logic/core_memsys.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/memsys_checker.sv
      - verification/memsys_tb.sv

//--- verification/memsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module memsys_tb;

	import core_pkg::*;

	localparam int NUM_CYCLES = 4000;
	localparam int MAX_LAT = 5;
	localparam ptr DATA_BASE = 30'h0100_0000; // Far above any fetch address.

	logic clk = 0;
	logic reset, flush, insn_take, insn_valid;
	logic data_req_valid, data_req_ready, data_rsp_valid;
	logic bus_start, bus_ready, bus_ex_fail;
	logic hold_take;
	ptr branch_target;
	fetch_entry_t insn_entry;
	data_req_t data_req;
	data_rsp_t data_rsp;
	bus_req_t bus_req, held_req;
	word bus_data_rd;
	word bus_mem [ptr];
	int mismatches, failures, outstanding, fetch_checked, data_checked;
	int delay;
	logic busy, fail;

	always #2 clk = ~clk;

	core_memsys dut_i (.*);

	memsys_checker #(.DATA_BASE(DATA_BASE)) checker_i (.*);

	function automatic word fill_word(input ptr a);
		return {a, 2'b01} ^ (32'(a) * 32'h9e3779b1);
	endfunction

	function automatic word bus_read(input ptr a);
		return bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
	endfunction

	// Bus memory with a latency of 1 to MAX_LAT cycles.
	always @(posedge clk) begin
		word merged;
		logic ex_store;
		if (reset) begin
			busy = 0;
			bus_ready <= 0;
			bus_ex_fail <= 0;
		end else begin
			bus_ready <= 0;
			bus_ex_fail <= 0;
			if (bus_start) begin
				busy = 1;
				delay = $urandom % MAX_LAT;
				held_req = bus_req;
			end
			if (busy && delay == 0) begin
				busy = 0;
				ex_store = held_req.write && held_req.ex_lock;
				fail = ex_store && ($urandom % 3 == 0);
				bus_ready <= 1;
				// Ex_fail is noise outside exclusive stores.
				bus_ex_fail <= ex_store ? fail : 1'($urandom);
				bus_data_rd <= bus_read(held_req.addr);
				if (held_req.write && !fail) begin
					merged = bus_read(held_req.addr);
					for (int i = 0; i < 4; i++)
						if (held_req.be[i])
							merged[8*i +: 8] = held_req.data_wr[8*i +: 8];
					bus_mem[held_req.addr] = merged;
				end
			end else if (busy)
				delay--;
		end
	end

	task automatic drive_cycle();
		logic do_flush;
		do_flush = $urandom % 64 == 0;
		flush <= do_flush;
		branch_target <= ptr'($urandom % 256);
		if ($urandom % 200 == 0)
			hold_take = !hold_take; // Long stretches without consuming.
		insn_take <= !do_flush && !hold_take && ($urandom % 4 != 0);
		if (!data_req_valid || data_req_ready) begin
			data_req_valid <= $urandom % 3 == 0;
			data_req.addr <= DATA_BASE + ptr'($urandom % 8);
			data_req.write <= $urandom % 2;
			data_req.ex_lock <= $urandom % 3 == 0;
			data_req.data_wr <= $urandom;
			data_req.be <= 4'($urandom);
		end
	endtask

	initial begin
		void'($urandom(61539));
		reset = 1;
		flush = 0;
		branch_target = '0;
		insn_take = 0;
		hold_take = 0;
		data_req_valid = 0;
		data_req = '0;
		bus_ready = 0;
		bus_ex_fail = 0;
		bus_data_rd = '0;
		repeat (16) @(posedge clk);
		reset <= 0;
		repeat (NUM_CYCLES) begin
			@(posedge clk);
			drive_cycle();
		end
		// Let the last request in and drain the responses.
		do begin
			@(posedge clk);
			flush <= 0;
			insn_take <= 1;
			if (data_req_ready)
				data_req_valid <= 0;
		end while (data_req_valid && !data_req_ready);
		do @(negedge clk); while (outstanding != 0 || data_req_valid);
		repeat (8) @(negedge clk);
		$display("fetch checked %0d, data checked %0d, mismatches %0d, other errors %0d",
			fetch_checked, data_checked, mismatches, failures);
		if (mismatches == 0 && failures == 0 && data_checked > 0 && fetch_checked > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#((NUM_CYCLES * MAX_LAT + 1000) * 4);
		$display("Timeout: the run did not finish in time, %0d data responses missing",
			outstanding);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/memsys_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module memsys_checker #(
	parameter core_pkg::ptr DATA_BASE = '0
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   flush,
	input  core_pkg::ptr           branch_target,
	input  logic                   insn_valid,
	input  core_pkg::fetch_entry_t insn_entry,
	input  logic                   insn_take,
	input  logic                   data_req_valid,
	input  core_pkg::data_req_t    data_req,
	input  logic                   data_req_ready,
	input  logic                   data_rsp_valid,
	input  core_pkg::data_rsp_t    data_rsp,
	input  logic                   bus_start,
	input  core_pkg::bus_req_t     bus_req,
	input  logic                   bus_ready,
	input  logic                   bus_ex_fail,
	output int                     mismatches,
	output int                     failures,
	output int                     outstanding,
	output int                     fetch_checked,
	output int                     data_checked
);

	import core_pkg::*;

	word model_mem [ptr];
	data_req_t req_q [$]; // Accepted, not yet answered.
	logic fail_q [$];     // Bus decisions on exclusive stores.
	ptr expect_pc;
	int queued, queued_last;
	logic open_txn, txn_is_data, flush_seen;

	function automatic word fill_value(input ptr a);
		return {a, 2'b01} ^ (32'(a) * 32'h9e3779b1);
	endfunction

	function automatic word model_read(input ptr a);
		return model_mem.exists(a) ? model_mem[a] : fill_value(a);
	endfunction

	function automatic word merge_bytes(input word old, input word nw, input logic [3:0] be);
		word res;
		res = old;
		for (int i = 0; i < 4; i++)
			if (be[i])
				res[8*i +: 8] = nw[8*i +: 8];
		return res;
	endfunction

	task automatic report_mismatch(input string msg);
		mismatches++;
		$display("MISMATCH at %0t: %s", $time, msg);
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	initial begin
		mismatches = 0;
		failures = 0;
		outstanding = 0;
		fetch_checked = 0;
		data_checked = 0;
	end

	always @(posedge clk) begin
		data_req_t r;
		logic exp_fail;
		if (reset) begin
			req_q.delete();
			fail_q.delete();
			expect_pc = '0;
			queued = 0;
			queued_last = 0;
			open_txn = 0;
			txn_is_data = 0;
			flush_seen = 0;
		end else begin
			if (flush_seen && insn_valid)
				report_failure("insn_valid was high in the cycle after a flush");
			if (flush)
				expect_pc = branch_target; // Take is ignored in a flush cycle.
			else if (insn_valid && insn_take) begin
				fetch_checked++;
				if (insn_entry.pc !== expect_pc)
					report_mismatch($sformatf("pc %h, expected %h", insn_entry.pc, expect_pc));
				else if (insn_entry.insn !== model_read(expect_pc))
					report_mismatch($sformatf("insn at pc %h is %h, expected %h",
						expect_pc, insn_entry.insn, model_read(expect_pc)));
				expect_pc = expect_pc + 1'b1;
			end
			flush_seen = flush;

			if (data_req_ready !== (queued < `CORE_DATA_QUEUE_DEPTH))
				report_mismatch($sformatf("data_req_ready %b with %0d requests queued",
					data_req_ready, queued));

			if (bus_start) begin
				if (open_txn)
					report_failure("second bus_start before bus_ready");
				open_txn = 1;
				txn_is_data = bus_req.addr >= DATA_BASE;
				if (queued_last > 0 && !txn_is_data)
					report_failure("fetch started while a data request was waiting");
			end
			if (bus_ready) begin
				if (!open_txn)
					report_failure("bus_ready without an open transaction");
				else if (txn_is_data && bus_req.write && bus_req.ex_lock)
					fail_q.push_back(bus_ex_fail);
				open_txn = 0;
			end

			queued_last = queued;
			if (bus_start && txn_is_data)
				queued--;
			if (data_req_valid && data_req_ready) begin
				req_q.push_back(data_req);
				queued++;
				outstanding++;
			end

			if (data_rsp_valid) begin
				if (req_q.size() == 0)
					report_failure("data response with no request outstanding");
				else begin
					r = req_q.pop_front();
					outstanding--;
					data_checked++;
					exp_fail = 0;
					if (r.write && r.ex_lock) begin
						if (fail_q.size() == 0)
							report_failure("exclusive store answered without a bus decision");
						else
							exp_fail = fail_q.pop_front();
					end
					if (data_rsp.ex_fail !== exp_fail)
						report_mismatch($sformatf("ex_fail %b at %h, expected %b",
							data_rsp.ex_fail, r.addr, exp_fail));
					if (r.write && !exp_fail)
						model_mem[r.addr] = merge_bytes(model_read(r.addr), r.data_wr, r.be);
					else if (!r.write && data_rsp.data_rd !== model_read(r.addr))
						report_mismatch($sformatf("load at %h returned %h, expected %h",
							r.addr, data_rsp.data_rd, model_read(r.addr)));
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/core_memsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_memsys (
	input  logic                   clk,
	input  logic                   reset,

	input  logic                   flush,
	input  core_pkg::ptr           branch_target,
	output logic                   insn_valid,
	output core_pkg::fetch_entry_t insn_entry,
	input  logic                   insn_take,

	input  logic                   data_req_valid,
	input  core_pkg::data_req_t    data_req,
	output logic                   data_req_ready,
	output logic                   data_rsp_valid,
	output core_pkg::data_rsp_t    data_rsp,

	output logic                   bus_start,
	output core_pkg::bus_req_t     bus_req,
	input  logic                   bus_ready,
	input  logic                   bus_ex_fail,
	input  core_pkg::word          bus_data_rd
);

	import core_pkg::*;

	ptr fetch_addr;
	word rsp_data_rd;
	bus_req_t data_bus_req;
	logic fetch_valid, fetch_grant, fetch_done;
	logic data_valid, data_grant, data_done, rsp_ex_fail;

	core_fetch #(.PREFETCH_ORDER(`CORE_PREFETCH_ORDER)) fetch
	(
		.fetch_data(rsp_data_rd),
		.*
	);

	core_data_port data
	(
		.mem_valid(data_valid),
		.mem_req(data_bus_req),
		.mem_grant(data_grant),
		.mem_done(data_done),
		.mem_data_rd(rsp_data_rd),
		.mem_ex_fail(rsp_ex_fail),
		.*
	);

	core_bus_arbiter arbiter
	(
		.*
	);

endmodule

`default_nettype wire

//--- logic/core_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module core_bus_arbiter (
	input  logic               clk,
	input  logic               reset,

	input  logic               data_valid,
	input  core_pkg::bus_req_t data_bus_req,
	output logic               data_grant,
	output logic               data_done,

	input  logic               fetch_valid,
	input  core_pkg::ptr       fetch_addr,
	output logic               fetch_grant,
	output logic               fetch_done,

	// Completion shared by both requesters.
	output core_pkg::word      rsp_data_rd,
	output logic               rsp_ex_fail,

	output logic               bus_start,
	output core_pkg::bus_req_t bus_req,
	input  logic               bus_ready,
	input  logic               bus_ex_fail,
	input  core_pkg::word      bus_data_rd
);

	import core_pkg::*;

	typedef enum logic {
		IDLE,
		BUSY
	} state_t;

	state_t state;
	logic owner_data; // Data port holds the bus.
	bus_req_t fetch_bus_req;

	assign fetch_bus_req = '{
		addr:    fetch_addr,
		write:   1'b0,
		ex_lock: 1'b0,
		data_wr: '0,
		be:      4'hf
	};

	assign data_grant = bus_start && owner_data;
	assign fetch_grant = bus_start && !owner_data;

	assign data_done = state == BUSY && bus_ready && owner_data;
	assign fetch_done = state == BUSY && bus_ready && !owner_data;

	assign rsp_data_rd = bus_data_rd;
	assign rsp_ex_fail = bus_ex_fail;

	always_ff @(posedge clk) begin
		bus_start <= 1'b0;

		if (reset) begin
			state <= IDLE;
			owner_data <= 1'b0;
		end else begin
			case (state)
				IDLE: if (data_valid || fetch_valid) begin
					state <= BUSY;
					owner_data <= data_valid; // Data wins ties.
					bus_start <= 1'b1;
				end
				BUSY: if (bus_ready)
					state <= IDLE;
			endcase
		end
	end

	// Held until the next pick, so stable for the whole transaction.
	always_ff @(posedge clk) begin
		if (state == IDLE)
			bus_req <= data_valid ? data_bus_req : fetch_bus_req;
	end

endmodule

`default_nettype wire

//--- logic/core_data_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_data_port (
	input  logic                clk,
	input  logic                reset,

	input  logic                data_req_valid,
	input  core_pkg::data_req_t data_req,
	output logic                data_req_ready,
	output logic                data_rsp_valid,
	output core_pkg::data_rsp_t data_rsp,

	output logic                mem_valid,
	output core_pkg::bus_req_t  mem_req,
	input  logic                mem_grant,
	input  logic                mem_done,
	input  core_pkg::word       mem_data_rd,
	input  logic                mem_ex_fail
);

	import core_pkg::*;

	localparam int DEPTH = `CORE_DATA_QUEUE_DEPTH;

	data_req_t head;
	logic empty, full, push;
	logic cur_ex_store; // Open transaction is an exclusive store.

	assign data_req_ready = !full;
	assign push = data_req_valid && data_req_ready;
	assign mem_valid = !empty;

	assign mem_req = '{
		addr:    head.addr,
		write:   head.write,
		ex_lock: head.ex_lock,
		data_wr: head.data_wr,
		be:      head.be
	};

	core_queue #(
		.entry_t(data_req_t),
		.DEPTH(DEPTH)
	) queue (
		.clk(clk),
		.reset(reset),
		.flush(1'b0),
		.push(push),
		.push_data(data_req),
		.pop(mem_grant), // Request leaves once the bus has it.
		.pop_data(head),
		.empty(empty),
		.full(full),
		.free()
	);

	always_ff @(posedge clk) begin
		if (reset)
			data_rsp_valid <= 1'b0;
		else
			data_rsp_valid <= mem_done;
	end

	always_ff @(posedge clk) begin
		if (mem_grant)
			cur_ex_store <= head.write && head.ex_lock;

		if (mem_done) begin
			data_rsp.data_rd <= mem_data_rd;
			data_rsp.ex_fail <= mem_ex_fail && cur_ex_store;
		end
	end

endmodule

`default_nettype wire

//--- logic/core_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_fetch #(
	parameter int PREFETCH_ORDER = `CORE_PREFETCH_ORDER
) (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  flush,
	input  core_pkg::ptr          branch_target,

	output logic                  insn_valid,
	output core_pkg::fetch_entry_t insn_entry,
	input  logic                  insn_take,

	output logic                  fetch_valid,
	output core_pkg::ptr          fetch_addr,
	input  logic                  fetch_grant,
	input  logic                  fetch_done,
	input  core_pkg::word         fetch_data
);

	import core_pkg::*;

	localparam int DEPTH = 1 << PREFETCH_ORDER;
	localparam int CNT_W = PREFETCH_ORDER + 1;

	ptr next_addr;   // Next word to request.
	ptr rsp_pc;      // Pc of the next live response.
	logic [CNT_W-1:0] inflight, discard, live, free;
	logic empty, push;
	fetch_entry_t push_entry;

	assign live = inflight - discard;
	assign fetch_addr = next_addr;

	// Every live fetch must find a free slot when it returns.
	assign fetch_valid = !flush && free > live;

	assign push = fetch_done && discard == '0 && !flush;
	assign push_entry = '{insn: fetch_data, pc: rsp_pc};

	assign insn_valid = !empty;

	core_queue #(
		.entry_t(fetch_entry_t),
		.DEPTH(DEPTH)
	) queue (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.push(push),
		.push_data(push_entry),
		.pop(insn_take),
		.pop_data(insn_entry),
		.empty(empty),
		.full(),
		.free(free)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			next_addr <= '0;
			rsp_pc <= '0;
			inflight <= '0;
			discard <= '0;
		end else begin
			inflight <= inflight + CNT_W'(fetch_grant) - CNT_W'(fetch_done);

			if (flush) begin
				next_addr <= branch_target;
				rsp_pc <= branch_target;
				// Whatever is still on the bus belongs to the old path.
				discard <= inflight + CNT_W'(fetch_grant) - CNT_W'(fetch_done);
			end else begin
				if (fetch_grant)
					next_addr <= next_addr + 1'b1;

				if (fetch_done && discard != '0)
					discard <= discard - 1'b1; // Stale word dropped.
				else if (fetch_done)
					rsp_pc <= rsp_pc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/core_queue.sv
`timescale 1ns/1ps
`default_nettype none

module core_queue #(
	parameter type entry_t = logic,
	parameter int  DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         flush,
	input  logic                         push,
	input  entry_t                       push_data,
	input  logic                         pop,
	output entry_t                       pop_data,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(DEPTH+1)-1:0]   free
);

	localparam int PTR_W = DEPTH > 1 ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	entry_t slots [DEPTH];
	logic [PTR_W-1:0] rd_ptr, wr_ptr;
	logic [CNT_W-1:0] count;
	logic do_push, do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return p == PTR_W'(DEPTH - 1) ? '0 : p + 1'b1;
	endfunction

	assign empty = count == '0;
	assign full = count == CNT_W'(DEPTH);
	assign free = CNT_W'(DEPTH) - count;
	assign pop_data = slots[rd_ptr]; // Head is always visible.

	assign do_pop = pop && !empty;
	assign do_push = push && (!full || do_pop); // Full queue may swap head for tail.

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push && !flush)
			slots[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

	typedef logic [`CORE_WORD_W-1:0] word;
	typedef logic [`CORE_WORD_W-3:0] ptr; // Word address.

	// What goes out on the shared bus.
	typedef struct packed {
		ptr         addr;
		logic       write;
		logic       ex_lock;
		word        data_wr;
		logic [3:0] be;
	} bus_req_t;

	// Issued by the data client.
	typedef struct packed {
		ptr         addr;
		logic       write;
		logic       ex_lock;
		word        data_wr;
		logic [3:0] be;
	} data_req_t;

	typedef struct packed {
		word  data_rd;
		logic ex_fail;
	} data_rsp_t;

	typedef struct packed {
		word insn;
		ptr  pc;
	} fetch_entry_t;

endpackage

`default_nettype wire

//--- logic/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width of the core.
`define CORE_WORD_W 32

// Prefetch queue holds 2**CORE_PREFETCH_ORDER words.
`define CORE_PREFETCH_ORDER 2

// Data requests that can wait ahead of the bus.
`define CORE_DATA_QUEUE_DEPTH 2

`endif
